//--- files.f
src/afu_cfg_pkg.sv
src/afu_regs_pkg.sv
src/afu_ifs.sv
src/afu_mmio_csr.sv
src/afu_cmd_fsm.sv
src/host_to_lmem_copy.sv
src/lmem_to_host_copy.sv
src/afu_top.sv
test/afu_mem_models.sv
test/afu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AFU testbench, result taken from sim.log
verilator --binary --timing --assert -Wno-fatal --top-module afu_tb -f files.f -o afu_sim &&
  ./obj_dir/afu_sim | tee sim.log &&
  ! grep -q "TESTS FAILED" sim.log &&
  grep -q "TESTS PASSED" sim.log ||
  { echo "Simulation did not pass"; exit 1; }

//--- src/afu_cfg_pkg.sv
package afu_cfg_pkg;

  // Host line and local memory line share one width
  localparam int LINE_WIDTH = 512;
  localparam int ADDR_WIDTH = 26;  // Line address, not byte address

  // Host read batching
  localparam int READ_WINDOW   = 8;
  localparam int RD_QUEUE_SIZE = 2 * READ_WINDOW;

  localparam int WR_PENDING_SIZE = 256;  // Host writes in flight

  typedef logic [LINE_WIDTH-1:0] line_t;
  typedef logic [ADDR_WIDTH-1:0] line_addr_t;
  typedef logic [$clog2(READ_WINDOW)-1:0] win_tag_t;

  // MMIO channel
  typedef logic [63:0] mmio_data_t;
  typedef logic [15:0] mmio_addr_t;
  typedef logic [8:0]  mmio_tid_t;

endpackage

//--- src/afu_cmd_fsm.sv
`timescale 1ns/1ps

module afu_cmd_fsm
  import afu_regs_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        write_done,
  input  logic        read_done,
  output copy_state_t state,
  cmd_if.fsm          cmd
);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd.cmd_valid && cmd.cmd_code == CMD_MEM_WRITE) begin
            state <= ST_WRITE;
          end else if (cmd.cmd_valid && cmd.cmd_code == CMD_MEM_READ) begin
            state <= ST_READ;
          end
        end
        ST_WRITE: begin
          if (write_done) state <= ST_IDLE;  // All lines in local memory
        end
        ST_READ: begin
          if (read_done) state <= ST_IDLE;   // All host writes acknowledged
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Engines only finish in their own state
  assert property (@(posedge clk) disable iff (reset)
    (write_done |-> state == ST_WRITE) and (read_done |-> state == ST_READ))
    else $error("Copy done flag outside its state");

endmodule

//--- src/afu_ifs.sv
`timescale 1ns/1ps

// Copy command registers, written over MMIO
interface cmd_if
  import afu_cfg_pkg::*;
();
  logic       cmd_valid;
  logic [2:0] cmd_code;
  line_addr_t io_addr;
  line_addr_t mem_addr;
  line_addr_t data_size;  // In lines

  modport master (output cmd_valid, cmd_code, io_addr, mem_addr, data_size);

  modport fsm (input cmd_valid, cmd_code);

  modport copy (input io_addr, mem_addr, data_size);
endinterface

// Single local memory port, one line per request
interface lmem_if
  import afu_cfg_pkg::*;
();
  logic       req_valid;
  logic       req_rw;     // High for write
  line_addr_t req_addr;
  line_t      req_data;
  line_addr_t req_tag;
  logic       req_ready;

  // Read data, in request order
  logic       rsp_valid;
  line_t      rsp_data;
  line_addr_t rsp_tag;

  modport master (
    output req_valid, req_rw, req_addr, req_data, req_tag,
    input  req_ready, rsp_valid, rsp_data, rsp_tag
  );
endinterface

//--- src/afu_mmio_csr.sv
`timescale 1ns/1ps

module afu_mmio_csr
  import afu_cfg_pkg::*;
  import afu_regs_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        mmio_wr_valid,
  input  logic        mmio_rd_valid,
  input  mmio_addr_t  mmio_addr,
  input  mmio_data_t  mmio_wdata,
  input  mmio_tid_t   mmio_tid,
  input  copy_state_t state,
  output logic        mmio_rsp_valid,
  output mmio_data_t  mmio_rsp_data,
  output mmio_tid_t   mmio_rsp_tid,
  cmd_if.master       cmd
);

  // Command goes to the FSM in the same cycle as the write
  assign cmd.cmd_valid = mmio_wr_valid && (mmio_addr == REG_CMD_TYPE);
  assign cmd.cmd_code  = mmio_wdata[2:0];

  always_ff @(posedge clk) begin
    if (mmio_wr_valid) begin
      case (mmio_addr)
        REG_IO_ADDR:   cmd.io_addr   <= line_addr_t'(mmio_wdata);
        REG_MEM_ADDR:  cmd.mem_addr  <= line_addr_t'(mmio_wdata);
        REG_DATA_SIZE: cmd.data_size <= line_addr_t'(mmio_wdata);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mmio_rsp_valid <= 1'b0;
    end else begin
      mmio_rsp_valid <= mmio_rd_valid;
    end
  end

  // Read data and tid, valid one cycle later
  always_ff @(posedge clk) begin
    if (mmio_rd_valid) begin
      mmio_rsp_tid <= mmio_tid;
      case (mmio_addr)
        REG_DFH:      mmio_rsp_data <= DFH_VALUE;
        REG_ID_L:     mmio_rsp_data <= {32'h0, AFU_ID[31:0]};
        REG_ID_H:     mmio_rsp_data <= {32'h0, AFU_ID[63:32]};
        REG_DEV_CAPS: mmio_rsp_data <= DEV_CAPS_VALUE;
        REG_STATUS:   mmio_rsp_data <= {56'h0, 8'(state)};
        default:      mmio_rsp_data <= '0;
      endcase
    end
  end

  // Host never issues both on one cycle
  assert property (@(posedge clk) disable iff (reset)
    !(mmio_wr_valid && mmio_rd_valid))
    else $error("MMIO read and write in the same cycle");

endmodule

//--- src/afu_regs_pkg.sv
package afu_regs_pkg;

  // MMIO offsets, in 32-bit words
  localparam logic [15:0] REG_DFH       = 16'h0000;
  localparam logic [15:0] REG_ID_L      = 16'h0002;
  localparam logic [15:0] REG_ID_H      = 16'h0004;
  localparam logic [15:0] REG_CMD_TYPE  = 16'h000A;
  localparam logic [15:0] REG_IO_ADDR   = 16'h000C;
  localparam logic [15:0] REG_MEM_ADDR  = 16'h000E;
  localparam logic [15:0] REG_DATA_SIZE = 16'h0010;
  localparam logic [15:0] REG_STATUS    = 16'h0012;
  localparam logic [15:0] REG_DEV_CAPS  = 16'h0018;

  localparam logic [2:0] CMD_MEM_READ  = 3'd1;  // Local memory to host
  localparam logic [2:0] CMD_MEM_WRITE = 3'd2;  // Host to local memory

  // AFU type, end of DFH list
  localparam logic [63:0] DFH_VALUE      = 64'h1000_0100_0000_0000;
  localparam logic [63:0] AFU_ID         = 64'h35f9_452b_25c2_434c;
  localparam logic [63:0] DEV_CAPS_VALUE = 64'h0004_0004_0001_0000;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_WRITE = 2'd1,
    ST_READ  = 2'd2
  } copy_state_t;

endpackage

//--- src/afu_top.sv
`timescale 1ns/1ps

module afu_top
  import afu_cfg_pkg::*;
  import afu_regs_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       mmio_wr_valid,
  input  logic       mmio_rd_valid,
  input  mmio_addr_t mmio_addr,
  input  mmio_data_t mmio_wdata,
  input  mmio_tid_t  mmio_tid,
  output logic       mmio_rsp_valid,
  output mmio_data_t mmio_rsp_data,
  output mmio_tid_t  mmio_rsp_tid,
  output logic       host_rd_req_valid,
  output line_addr_t host_rd_req_addr,
  output win_tag_t   host_rd_req_tag,
  input  logic       host_rd_almfull,
  input  logic       host_rd_rsp_valid,
  input  line_t      host_rd_rsp_data,
  input  win_tag_t   host_rd_rsp_tag,
  output logic       host_wr_req_valid,
  output line_addr_t host_wr_req_addr,
  output line_t      host_wr_req_data,
  input  logic       host_wr_almfull,
  input  logic       host_wr_rsp_valid,
  output logic       lmem_req_valid,
  output logic       lmem_req_rw,
  output line_addr_t lmem_req_addr,
  output line_t      lmem_req_data,
  output line_addr_t lmem_req_tag,
  input  logic       lmem_req_ready,
  input  logic       lmem_rsp_valid,
  input  line_t      lmem_rsp_data,
  input  line_addr_t lmem_rsp_tag
);
  copy_state_t state;
  logic        write_done, read_done;
  logic        wr_sel, rd_sel;

  cmd_if  cmd_bus ();
  lmem_if h2l_mem ();
  lmem_if l2h_mem ();

  assign wr_sel = (state == ST_WRITE);
  assign rd_sel = (state == ST_READ);

  // Local memory port follows the active copy
  assign lmem_req_valid = wr_sel ? h2l_mem.req_valid : l2h_mem.req_valid;
  assign lmem_req_rw    = wr_sel ? h2l_mem.req_rw    : l2h_mem.req_rw;
  assign lmem_req_addr  = wr_sel ? h2l_mem.req_addr  : l2h_mem.req_addr;
  assign lmem_req_data  = wr_sel ? h2l_mem.req_data  : l2h_mem.req_data;
  assign lmem_req_tag   = wr_sel ? h2l_mem.req_tag   : l2h_mem.req_tag;

  assign h2l_mem.req_ready = wr_sel && lmem_req_ready;
  assign h2l_mem.rsp_valid = wr_sel && lmem_rsp_valid;
  assign h2l_mem.rsp_data  = lmem_rsp_data;
  assign h2l_mem.rsp_tag   = lmem_rsp_tag;

  assign l2h_mem.req_ready = rd_sel && lmem_req_ready;
  assign l2h_mem.rsp_valid = rd_sel && lmem_rsp_valid;
  assign l2h_mem.rsp_data  = lmem_rsp_data;
  assign l2h_mem.rsp_tag   = lmem_rsp_tag;

  afu_mmio_csr csr_i (
    .clk            (clk),
    .reset          (reset),
    .mmio_wr_valid  (mmio_wr_valid),
    .mmio_rd_valid  (mmio_rd_valid),
    .mmio_addr      (mmio_addr),
    .mmio_wdata     (mmio_wdata),
    .mmio_tid       (mmio_tid),
    .state          (state),
    .mmio_rsp_valid (mmio_rsp_valid),
    .mmio_rsp_data  (mmio_rsp_data),
    .mmio_rsp_tid   (mmio_rsp_tid),
    .cmd            (cmd_bus)
  );

  afu_cmd_fsm fsm_i (
    .clk        (clk),
    .reset      (reset),
    .write_done (write_done),
    .read_done  (read_done),
    .state      (state),
    .cmd        (cmd_bus)
  );

  host_to_lmem_copy #(
    .READ_WINDOW   (READ_WINDOW),
    .RD_QUEUE_SIZE (RD_QUEUE_SIZE)
  ) h2l_i (
    .clk               (clk),
    .reset             (reset),
    .state             (state),
    .host_rd_almfull   (host_rd_almfull),
    .host_rd_rsp_valid (wr_sel && host_rd_rsp_valid),
    .host_rd_rsp_data  (host_rd_rsp_data),
    .host_rd_rsp_tag   (host_rd_rsp_tag),
    .write_done        (write_done),
    .host_rd_req_valid (host_rd_req_valid),
    .host_rd_req_addr  (host_rd_req_addr),
    .host_rd_req_tag   (host_rd_req_tag),
    .cmd               (cmd_bus),
    .mem               (h2l_mem)
  );

  lmem_to_host_copy #(
    .WR_PENDING_SIZE (WR_PENDING_SIZE)
  ) l2h_i (
    .clk               (clk),
    .reset             (reset),
    .state             (state),
    .host_wr_almfull   (host_wr_almfull),
    .host_wr_rsp_valid (rd_sel && host_wr_rsp_valid),
    .read_done         (read_done),
    .host_wr_req_valid (host_wr_req_valid),
    .host_wr_req_addr  (host_wr_req_addr),
    .host_wr_req_data  (host_wr_req_data),
    .cmd               (cmd_bus),
    .mem               (l2h_mem)
  );

endmodule

//--- src/host_to_lmem_copy.sv
`timescale 1ns/1ps

module host_to_lmem_copy
  import afu_cfg_pkg::*;
  import afu_regs_pkg::*;
#(
  parameter int READ_WINDOW   = afu_cfg_pkg::READ_WINDOW,
  parameter int RD_QUEUE_SIZE = afu_cfg_pkg::RD_QUEUE_SIZE
) (
  input  logic                           clk,
  input  logic                           reset,
  input  copy_state_t                    state,
  input  logic                           host_rd_almfull,
  input  logic                           host_rd_rsp_valid,
  input  line_t                          host_rd_rsp_data,
  input  logic [$clog2(READ_WINDOW)-1:0] host_rd_rsp_tag,
  output logic                           write_done,
  output logic                           host_rd_req_valid,
  output line_addr_t                     host_rd_req_addr,
  output logic [$clog2(READ_WINDOW)-1:0] host_rd_req_tag,
  cmd_if.copy                            cmd,
  lmem_if.master                         mem
);
  localparam int TAG_W = $clog2(READ_WINDOW);
  localparam int PTR_W = $clog2(RD_QUEUE_SIZE);
  localparam int CNT_W = $clog2(RD_QUEUE_SIZE + 1);

  line_t            q_data [RD_QUEUE_SIZE];
  line_addr_t       q_addr [RD_QUEUE_SIZE];
  logic [PTR_W:0]   q_wr_ptr, q_rd_ptr, q_count;
  logic             q_push, q_pop;
  logic [CNT_W-1:0] pending;  // Issued reads not yet written out
  line_addr_t       rd_addr, rd_ctr, wr_base, wr_ctr;
  logic [TAG_W-1:0] rsp_ctr;
  logic             rd_wait;
  logic [READ_WINDOW-1:0] rsp_mask;

  assign host_rd_req_valid = (state == ST_WRITE) && (rd_ctr != cmd.data_size) && !rd_wait
                          && !host_rd_almfull && (pending != CNT_W'(RD_QUEUE_SIZE));
  assign host_rd_req_addr  = rd_addr;
  assign host_rd_req_tag   = rd_ctr[TAG_W-1:0];

  assign q_push  = host_rd_rsp_valid;
  assign q_pop   = mem.req_valid && mem.req_ready;
  assign q_count = q_wr_ptr - q_rd_ptr;

  assign mem.req_valid = (q_count != '0);
  assign mem.req_rw    = 1'b1;
  assign mem.req_addr  = q_addr[q_rd_ptr[PTR_W-1:0]];
  assign mem.req_data  = q_data[q_rd_ptr[PTR_W-1:0]];
  assign mem.req_tag   = wr_ctr;

  assign write_done = (state == ST_WRITE) && (wr_ctr == cmd.data_size);

  always_ff @(posedge clk) begin
    if (reset || state != ST_WRITE) begin
      rd_ctr   <= '0;
      rd_wait  <= 1'b0;
      rsp_ctr  <= '0;
      rsp_mask <= '0;
      wr_ctr   <= '0;
    end else begin
      if (host_rd_req_valid) begin
        rd_ctr <= rd_ctr + 1'b1;
        if (host_rd_req_tag == TAG_W'(READ_WINDOW - 1)) rd_wait <= 1'b1;  // Window issued
      end
      if (q_push) begin
        rsp_ctr  <= rsp_ctr + 1'b1;
        rsp_mask <= ((rsp_ctr == '0) ? '0 : rsp_mask) | (READ_WINDOW'(1) << host_rd_rsp_tag);
        if (rsp_ctr == TAG_W'(READ_WINDOW - 1)) rd_wait <= 1'b0;
      end
      if (q_pop) wr_ctr <= wr_ctr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
      pending  <= '0;
    end else begin
      if (q_push) q_wr_ptr <= q_wr_ptr + 1'b1;
      if (q_pop) q_rd_ptr <= q_rd_ptr + 1'b1;
      pending <= pending + CNT_W'(host_rd_req_valid) - CNT_W'(q_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (state != ST_WRITE) begin
      rd_addr <= cmd.io_addr;
      wr_base <= cmd.mem_addr;
    end else begin
      if (host_rd_req_valid) rd_addr <= rd_addr + 1'b1;
      if (q_push && rsp_ctr == TAG_W'(READ_WINDOW - 1)) begin
        wr_base <= wr_base + line_addr_t'(READ_WINDOW);  // Next window base
      end
    end
    if (q_push) begin
      q_data[q_wr_ptr[PTR_W-1:0]] <= host_rd_rsp_data;
      q_addr[q_wr_ptr[PTR_W-1:0]] <= wr_base + line_addr_t'(host_rd_rsp_tag);
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    q_push && !q_pop |-> q_count != (PTR_W + 1)'(RD_QUEUE_SIZE))
    else $error("Host read response queue overflow");

  assert property (@(posedge clk) disable iff (reset)
    q_push && rsp_ctr != '0 |-> !rsp_mask[host_rd_rsp_tag])
    else $error("Host read tag repeated within a window");

endmodule

//--- src/lmem_to_host_copy.sv
`timescale 1ns/1ps

module lmem_to_host_copy
  import afu_cfg_pkg::*;
  import afu_regs_pkg::*;
#(
  parameter int WR_PENDING_SIZE = afu_cfg_pkg::WR_PENDING_SIZE
) (
  input  logic        clk,
  input  logic        reset,
  input  copy_state_t state,
  input  logic        host_wr_almfull,
  input  logic        host_wr_rsp_valid,
  output logic        read_done,
  output logic        host_wr_req_valid,
  output line_addr_t  host_wr_req_addr,
  output line_t       host_wr_req_data,
  cmd_if.copy         cmd,
  lmem_if.master      mem
);
  localparam int PEND_W = $clog2(WR_PENDING_SIZE + 1);

  line_addr_t        rd_addr;
  line_addr_t        rd_ctr;   // Local reads accepted
  line_addr_t        wr_ctr;   // Host writes issued
  logic [PEND_W-1:0] pending;  // From local read to host write response
  logic              rd_fire;

  assign mem.req_valid = (state == ST_READ) && (rd_ctr != cmd.data_size) && !host_wr_almfull
                      && (pending != PEND_W'(WR_PENDING_SIZE));
  assign mem.req_rw    = 1'b0;
  assign mem.req_addr  = rd_addr;
  assign mem.req_data  = '0;
  assign mem.req_tag   = rd_ctr;  // Line index, offset into io_addr
  assign rd_fire       = mem.req_valid && mem.req_ready;

  assign read_done = (state == ST_READ) && (wr_ctr == cmd.data_size) && (pending == '0);

  always_ff @(posedge clk) begin
    if (reset || state != ST_READ) begin
      rd_ctr <= '0;
      wr_ctr <= '0;
    end else begin
      if (rd_fire) rd_ctr <= rd_ctr + 1'b1;
      if (host_wr_req_valid) wr_ctr <= wr_ctr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      host_wr_req_valid <= 1'b0;
      pending           <= '0;
    end else begin
      host_wr_req_valid <= mem.rsp_valid;
      pending <= pending + PEND_W'(rd_fire) - PEND_W'(host_wr_rsp_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (state != ST_READ) begin
      rd_addr <= cmd.mem_addr;
    end else if (rd_fire) begin
      rd_addr <= rd_addr + 1'b1;
    end
    host_wr_req_addr <= cmd.io_addr + mem.rsp_tag;
    host_wr_req_data <= mem.rsp_data;
  end

  assert property (@(posedge clk) disable iff (reset)
    host_wr_rsp_valid |-> pending != '0)
    else $error("Host write response with nothing pending");

endmodule

//--- test/afu_mem_models.sv
`timescale 1ns/1ps

// Host memory, reads answered in shuffled order, writes acked later
module host_mem_model
  import afu_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        heavy,
  input  logic [10:0] rnd_bits,
  input  logic        host_rd_req_valid,
  input  line_addr_t  host_rd_req_addr,
  input  win_tag_t    host_rd_req_tag,
  output logic        host_rd_almfull,
  output logic        host_rd_rsp_valid,
  output line_t       host_rd_rsp_data,
  output win_tag_t    host_rd_rsp_tag,
  input  logic        host_wr_req_valid,
  input  line_addr_t  host_wr_req_addr,
  input  line_t       host_wr_req_data,
  output logic        host_wr_almfull,
  output logic        host_wr_rsp_valid
);
  line_t      mem [256];
  line_addr_t rd_q_addr [$];  // Reads waiting for a response
  win_tag_t   rd_q_tag [$];
  int         wr_acks;

  function automatic line_t fill_line(input int a);
    line_t l;
    for (int w = 0; w < 16; w++) begin
      l[w*32 +: 32] = (32'(a) * 32'h9e37_79b1) ^ (32'(w) << 20) ^ 32'h4005_0000;
    end
    return l;
  endfunction

  initial begin
    host_rd_almfull   = 1'b0;
    host_rd_rsp_valid = 1'b0;
    host_rd_rsp_data  = '0;
    host_rd_rsp_tag   = '0;
    host_wr_almfull   = 1'b0;
    host_wr_rsp_valid = 1'b0;
  end

  always @(posedge clk) begin : host_side
    int         pick;
    line_addr_t a;
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= fill_line(i);
      end
      rd_q_addr.delete();
      rd_q_tag.delete();
      wr_acks = 0;
      host_rd_almfull   <= 1'b0;
      host_rd_rsp_valid <= 1'b0;
      host_wr_almfull   <= 1'b0;
      host_wr_rsp_valid <= 1'b0;
    end else begin
      host_rd_almfull <= heavy ? (rnd_bits[1:0] != 2'd0) : (rnd_bits[1:0] == 2'd0);
      host_wr_almfull <= heavy ? (rnd_bits[3:2] != 2'd0) : (rnd_bits[3:2] == 2'd0);
      if (host_rd_req_valid) begin
        rd_q_addr.push_back(host_rd_req_addr);
        rd_q_tag.push_back(host_rd_req_tag);
      end
      host_rd_rsp_valid <= 1'b0;
      if (rd_q_addr.size() != 0 && rnd_bits[4]) begin
        pick = int'(rnd_bits[9:5]) % rd_q_addr.size();  // Any read still open
        a = rd_q_addr[pick];
        host_rd_rsp_valid <= 1'b1;
        host_rd_rsp_data  <= mem[a[7:0]];
        host_rd_rsp_tag   <= rd_q_tag[pick];
        rd_q_addr.delete(pick);
        rd_q_tag.delete(pick);
      end
      if (host_wr_req_valid) begin
        a = host_wr_req_addr;
        mem[a[7:0]] <= host_wr_req_data;
        wr_acks++;
      end
      host_wr_rsp_valid <= 1'b0;
      if (wr_acks > 0 && rnd_bits[10]) begin
        host_wr_rsp_valid <= 1'b1;
        wr_acks--;
      end
    end
  end

endmodule

// Local memory, in-order read data after 1 to 4 cycles
module lmem_model
  import afu_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       heavy,
  input  logic [4:0] rnd_bits,
  input  logic       lmem_req_valid,
  input  logic       lmem_req_rw,
  input  line_addr_t lmem_req_addr,
  input  line_t      lmem_req_data,
  input  line_addr_t lmem_req_tag,
  output logic       lmem_req_ready,
  output logic       lmem_rsp_valid,
  output line_t      lmem_rsp_data,
  output line_addr_t lmem_rsp_tag
);
  line_t      mem [256];
  line_t      q_data [$];
  line_addr_t q_tag [$];
  int         q_due [$];
  int         cycle;

  function automatic line_t fill_line(input int a);
    line_t l;
    for (int w = 0; w < 16; w++) begin
      l[w*32 +: 32] = (32'(a) * 32'h85eb_ca6b) ^ (32'(w) << 24) ^ 32'h0000_7e11;
    end
    return l;
  endfunction

  initial begin
    lmem_req_ready = 1'b0;
    lmem_rsp_valid = 1'b0;
    lmem_rsp_data  = '0;
    lmem_rsp_tag   = '0;
  end

  always @(posedge clk) begin : lmem_side
    line_addr_t a;
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= fill_line(i);
      end
      q_data.delete();
      q_tag.delete();
      q_due.delete();
      cycle = 0;
      lmem_req_ready <= 1'b0;
      lmem_rsp_valid <= 1'b0;
    end else begin
      cycle++;
      lmem_req_ready <= heavy ? (rnd_bits[1:0] == 2'd0) : (rnd_bits[2:0] != 3'd0);
      if (lmem_req_valid && lmem_req_ready) begin
        a = lmem_req_addr;
        if (lmem_req_rw) begin
          mem[a[7:0]] <= lmem_req_data;
        end else begin
          q_data.push_back(mem[a[7:0]]);
          q_tag.push_back(lmem_req_tag);
          q_due.push_back(cycle + int'(rnd_bits[4:3]));
        end
      end
      lmem_rsp_valid <= 1'b0;
      if (q_due.size() != 0 && q_due[0] <= cycle) begin  // Head first, keeps order
        lmem_rsp_valid <= 1'b1;
        lmem_rsp_data  <= q_data.pop_front();
        lmem_rsp_tag   <= q_tag.pop_front();
        void'(q_due.pop_front());
      end
    end
  end

endmodule

//--- test/afu_tb.sv
`timescale 1ns/1ps

module afu_tb
  import afu_cfg_pkg::*;
  import afu_regs_pkg::*;
();
  localparam int MEM_LINES  = 256;
  localparam int POLL_LIMIT = 3000;

  typedef struct packed {
    logic [2:0] cmd;
    logic [7:0] io;
    logic [7:0] mem;
    logic [7:0] size;
    logic       heavy;  // Heavy almfull and ready throttling
    logic       extra;  // Second command while busy
  } row_t;

  localparam row_t ROWS [7] = '{
    '{CMD_MEM_WRITE, 8'd10,  8'd40,  8'd16, 1'b0, 1'b0},
    '{CMD_MEM_WRITE, 8'd100, 8'd3,   8'd11, 1'b0, 1'b1},
    '{CMD_MEM_READ,  8'd60,  8'd120, 8'd5,  1'b0, 1'b0},
    '{CMD_MEM_READ,  8'd200, 8'd30,  8'd20, 1'b0, 1'b1},
    '{CMD_MEM_WRITE, 8'd33,  8'd150, 8'd16, 1'b1, 1'b0},
    '{CMD_MEM_READ,  8'd7,   8'd90,  8'd20, 1'b1, 1'b1},
    '{CMD_MEM_WRITE, 8'd170, 8'd210, 8'd11, 1'b1, 1'b0}
  };

  logic       clk = 1'b0;
  logic       reset = 1'b1;
  logic       mmio_wr_valid, mmio_rd_valid, mmio_rsp_valid;
  mmio_addr_t mmio_addr;
  mmio_data_t mmio_wdata, mmio_rsp_data;
  mmio_tid_t  mmio_tid, mmio_rsp_tid;
  logic       host_rd_req_valid, host_rd_almfull, host_rd_rsp_valid;
  line_addr_t host_rd_req_addr;
  win_tag_t   host_rd_req_tag, host_rd_rsp_tag;
  line_t      host_rd_rsp_data, host_wr_req_data;
  logic       host_wr_req_valid, host_wr_almfull, host_wr_rsp_valid;
  line_addr_t host_wr_req_addr;
  logic       lmem_req_valid, lmem_req_rw, lmem_req_ready, lmem_rsp_valid;
  line_addr_t lmem_req_addr, lmem_req_tag, lmem_rsp_tag;
  line_t      lmem_req_data, lmem_rsp_data;

  logic [31:0] lfsr = 32'h8ec3_044e;
  logic [15:0] rnd = '0;
  logic        heavy = 1'b0;
  line_t       host_snap [MEM_LINES];
  line_t       lmem_snap [MEM_LINES];

  afu_top dut_i (.*);
  host_mem_model host_i (.rnd_bits(rnd[10:0]), .*);
  lmem_model lmem_i (.rnd_bits(rnd[15:11]), .*);

  always #2 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(posedge clk) begin : rand_gen
    logic [31:0] s;
    logic [15:0] bits;
    s = lfsr;
    for (int i = 0; i < 16; i++) begin
      s = lfsr_step(s);
      bits[i] = s[0];
    end
    lfsr <= s;
    rnd  <= bits;
  end

  task automatic check_value(input string what, input line_t got, input line_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic mmio_write(input mmio_addr_t addr, input mmio_data_t data);
    @(posedge clk);
    mmio_wr_valid <= 1'b1;
    mmio_addr     <= addr;
    mmio_wdata    <= data;
    @(posedge clk);
    mmio_wr_valid <= 1'b0;
  endtask

  // Response must show up exactly one cycle after the request
  task automatic mmio_read(input mmio_addr_t addr, input mmio_tid_t tid,
                           output mmio_data_t data);
    @(posedge clk);
    mmio_rd_valid <= 1'b1;
    mmio_addr     <= addr;
    mmio_tid      <= tid;
    @(negedge clk);
    check_value("early mmio_rsp_valid", line_t'(mmio_rsp_valid), '0);
    @(posedge clk);
    mmio_rd_valid <= 1'b0;
    @(negedge clk);
    check_value("mmio_rsp_valid", line_t'(mmio_rsp_valid), line_t'(1'b1));
    check_value("mmio_rsp_tid", line_t'(mmio_rsp_tid), line_t'(tid));
    data = mmio_rsp_data;
  endtask

  task automatic wait_idle(input int idx, input mmio_data_t busy);
    mmio_data_t rdata;
    int         polls;
    polls = 0;
    rdata = busy;
    while (rdata != 64'(ST_IDLE) && polls < POLL_LIMIT) begin
      mmio_read(REG_STATUS, 9'(idx), rdata);
      if (rdata != 64'(ST_IDLE)) begin
        check_value("status while busy", line_t'(rdata), line_t'(busy));
      end
      polls++;
    end
    if (rdata != 64'(ST_IDLE)) begin
      $display("Copy of table row %0d never went back to idle after %0d status reads",
               idx, polls);
      $display("TESTS FAILED");
      $fatal(1, "Copy timeout");
    end
  endtask

  task automatic run_copy(input row_t r, input int idx);
    mmio_data_t rdata, busy;
    line_t      exp_line;
    int         io, mem, size;
    io   = int'(r.io);
    mem  = int'(r.mem);
    size = int'(r.size);
    busy = (r.cmd == CMD_MEM_WRITE) ? 64'(ST_WRITE) : 64'(ST_READ);
    for (int a = 0; a < MEM_LINES; a++) begin
      host_snap[a] = host_i.mem[a];
      lmem_snap[a] = lmem_i.mem[a];
    end
    @(posedge clk);
    heavy <= r.heavy;
    mmio_write(REG_IO_ADDR, 64'(r.io));
    mmio_write(REG_MEM_ADDR, 64'(r.mem));
    mmio_write(REG_DATA_SIZE, 64'(r.size));
    mmio_write(REG_CMD_TYPE, 64'(r.cmd));
    mmio_read(REG_STATUS, 9'(idx), rdata);
    check_value("status after command", line_t'(rdata), line_t'(busy));
    if (r.extra) begin
      // Opposite command, must be dropped
      mmio_write(REG_CMD_TYPE, (r.cmd == CMD_MEM_WRITE) ? 64'(CMD_MEM_READ)
                                                        : 64'(CMD_MEM_WRITE));
    end
    wait_idle(idx, busy);
    for (int a = 0; a < MEM_LINES; a++) begin
      if (r.cmd == CMD_MEM_WRITE) begin
        exp_line = (a >= mem && a < mem + size) ? host_snap[io + a - mem] : lmem_snap[a];
        check_value($sformatf("row %0d local line %0d", idx, a), lmem_i.mem[a], exp_line);
        check_value($sformatf("row %0d host line %0d", idx, a), host_i.mem[a], host_snap[a]);
      end else begin
        exp_line = (a >= io && a < io + size) ? lmem_snap[mem + a - io] : host_snap[a];
        check_value($sformatf("row %0d host line %0d", idx, a), host_i.mem[a], exp_line);
        check_value($sformatf("row %0d local line %0d", idx, a), lmem_i.mem[a], lmem_snap[a]);
      end
    end
  endtask

  initial begin
    mmio_data_t rdata;
    mmio_wr_valid = 1'b0;
    mmio_rd_valid = 1'b0;
    mmio_addr     = '0;
    mmio_wdata    = '0;
    mmio_tid      = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("mmio_rsp_valid after reset", line_t'(mmio_rsp_valid), '0);
    check_value("host_rd_req_valid after reset", line_t'(host_rd_req_valid), '0);
    check_value("host_wr_req_valid after reset", line_t'(host_wr_req_valid), '0);
    check_value("lmem_req_valid after reset", line_t'(lmem_req_valid), '0);

    // Fixed registers
    mmio_read(REG_DFH, 9'h011, rdata);
    check_value("DFH", line_t'(rdata), line_t'(DFH_VALUE));
    mmio_read(REG_ID_L, 9'h0a2, rdata);
    check_value("ID low", line_t'(rdata), line_t'({32'h0, AFU_ID[31:0]}));
    mmio_read(REG_ID_H, 9'h153, rdata);
    check_value("ID high", line_t'(rdata), line_t'({32'h0, AFU_ID[63:32]}));
    mmio_read(REG_DEV_CAPS, 9'h1ff, rdata);
    check_value("DEV_CAPS", line_t'(rdata), line_t'(DEV_CAPS_VALUE));
    mmio_read(16'h0030, 9'h064, rdata);
    check_value("unused offset", line_t'(rdata), '0);
    mmio_read(REG_STATUS, 9'h100, rdata);
    check_value("idle status", line_t'(rdata), line_t'(64'(ST_IDLE)));

    for (int i = 0; i < 7; i++) begin
      run_copy(ROWS[i], i);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule
